//--- verilog/fpga_reg_pkg.sv
//--------------------------------------------------------------------------
// register widths, host address map, opcode and frame state enums
//--------------------------------------------------------------------------
package fpga_reg_pkg;

    //----------------------------------------------------------------------
    // widths and base types
    //----------------------------------------------------------------------
    localparam int REG_DWIDTH = 16;
    localparam int REG_AWIDTH = 7;   // msb of the spi address byte is the opcode

    typedef logic [REG_DWIDTH-1:0] reg_data_t;
    typedef logic [REG_AWIDTH-1:0] reg_addr_t;

    // opcode bit of the address byte
    typedef enum logic {
        REG_OP_WR = 1'b0,
        REG_OP_RD = 1'b1
    } reg_op_e;

    // spi frame engine states
    typedef enum logic [2:0] {
        IDLE,
        ADDR,       // shifting the address byte
        REQ,        // req high, waiting for ack
        WAIT_ACK,   // req low, waiting for ack to drop
        DATA,       // write data in or read data out
        DONE        // frame finished, waiting for cs release
    } frame_state_e;

    //----------------------------------------------------------------------
    // address map
    //----------------------------------------------------------------------
    // read only status
    localparam reg_addr_t ADDR_FW_DATE_LO  = 7'h00;
    localparam reg_addr_t ADDR_FW_DATE_HI  = 7'h01;
    localparam reg_addr_t ADDR_FW_TIME_LO  = 7'h02;
    localparam reg_addr_t ADDR_FW_TIME_HI  = 7'h03;
    localparam reg_addr_t ADDR_MAC_LINK    = 7'h04;

    // read/write phy management
    localparam reg_addr_t ADDR_PHY_RST     = 7'h05;
    localparam reg_addr_t ADDR_MDIO_CLK    = 7'h06;   // bit 0 drives mdc
    localparam reg_addr_t ADDR_MDIO_DATA_O = 7'h07;
    localparam reg_addr_t ADDR_MDIO_DIR    = 7'h08;   // 1 = fpga drives mdio
    localparam reg_addr_t ADDR_MDIO_DATA_I = 7'h09;   // read only

    // first of the consecutive scratch registers
    localparam reg_addr_t ADDR_TEST_ARRAY  = 7'h10;

endpackage

//--- verilog/reg_bus_if.sv
//--------------------------------------------------------------------------
// register request channel, frame engine to register bank
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface reg_bus_if;

    // four phase req/ack with op/addr/wdata held while req is high
    logic                    req;
    fpga_reg_pkg::reg_op_e   op;
    fpga_reg_pkg::reg_addr_t addr;
    fpga_reg_pkg::reg_data_t wdata;

    logic                    ack;
    fpga_reg_pkg::reg_data_t rdata;   // valid together with ack

    modport host (
        output req,
        output op,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport bank (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

//--- verilog/spi_pin_sync.sv
//--------------------------------------------------------------------------
// spi pin synchronizers and spi clock edge detection
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_pin_sync (
    input  logic clk125M,
    input  logic rst_i,
    input  logic spi_clk_i,
    input  logic spi_cs_n_i,
    input  logic spi_mosi_i,
    output logic sclk_rise_o,
    output logic sclk_fall_o,
    output logic cs_active_o,
    output logic mosi_o
);

    // bit positions in the pin vectors
    localparam int SCLK_BIT = 2;
    localparam int CS_BIT   = 1;
    localparam int MOSI_BIT = 0;

    logic [2:0] pin_meta;   // first flop may go metastable
    logic [2:0] pin_sync;
    logic       sclk_prev;

    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            pin_meta    <= 3'b010;   // cs_n idles high
            pin_sync    <= 3'b010;
            sclk_prev   <= 1'b0;
            sclk_rise_o <= 1'b0;
            sclk_fall_o <= 1'b0;
            cs_active_o <= 1'b0;
            mosi_o      <= 1'b0;
        end else begin
            pin_meta  <= {spi_clk_i, spi_cs_n_i, spi_mosi_i};
            pin_sync  <= pin_meta;
            sclk_prev <= pin_sync[SCLK_BIT];

            // edges only count inside a frame
            sclk_rise_o <= pin_sync[SCLK_BIT] & ~sclk_prev & ~pin_sync[CS_BIT];
            sclk_fall_o <= ~pin_sync[SCLK_BIT] & sclk_prev & ~pin_sync[CS_BIT];
            cs_active_o <= ~pin_sync[CS_BIT];
            mosi_o      <= pin_sync[MOSI_BIT];   // same delay as the edge pulses
        end
    end

endmodule

//--- verilog/spi_frame.sv
//--------------------------------------------------------------------------
// spi frame engine with address byte and data shifting, request handshake
// and read data shift out on miso
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_frame (
    input  logic       clk125M,
    input  logic       rst_i,
    input  logic       sclk_rise_i,
    input  logic       sclk_fall_i,
    input  logic       cs_active_i,
    input  logic       mosi_i,
    output logic       spi_miso_o,
    reg_bus_if.host    bus
);

    // bit counter values of the last address bit and the last frame bit
    localparam logic [4:0] ADDR_LAST  = 5'(fpga_reg_pkg::REG_AWIDTH);
    localparam logic [4:0] FRAME_LAST =
        5'(fpga_reg_pkg::REG_AWIDTH + fpga_reg_pkg::REG_DWIDTH);

    fpga_reg_pkg::frame_state_e state;
    logic [4:0]                 bit_cnt;   // rising edges seen in this frame
    logic                       req_q;

    logic [7:0]                 addr_byte;   // {opcode, address}
    logic [7:0]                 addr_next;
    fpga_reg_pkg::reg_op_e      frame_op;
    fpga_reg_pkg::reg_data_t    wr_data;
    fpga_reg_pkg::reg_data_t    rd_shift;

    assign addr_next = {addr_byte[6:0], mosi_i};
    assign frame_op  = fpga_reg_pkg::reg_op_e'(addr_byte[7]);

    assign bus.req   = req_q;
    assign bus.op    = frame_op;
    assign bus.addr  = addr_byte[fpga_reg_pkg::REG_AWIDTH-1:0];
    assign bus.wdata = wr_data;

    //----------------------------------------------------------------------
    // control FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            state      <= fpga_reg_pkg::IDLE;
            bit_cnt    <= '0;
            req_q      <= 1'b0;
            spi_miso_o <= 1'b0;
        end else begin
            case (state)
                fpga_reg_pkg::IDLE: begin
                    bit_cnt    <= '0;
                    spi_miso_o <= 1'b0;
                    if (cs_active_i) state <= fpga_reg_pkg::ADDR;
                end

                fpga_reg_pkg::ADDR: begin
                    if (!cs_active_i) begin
                        state <= fpga_reg_pkg::IDLE;   // short frame is dropped
                    end else if (sclk_rise_i) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == ADDR_LAST) begin
                            // reads go to the bank right after the address byte
                            if (fpga_reg_pkg::reg_op_e'(addr_next[7]) ==
                                fpga_reg_pkg::REG_OP_RD) begin
                                state <= fpga_reg_pkg::REQ;
                                req_q <= 1'b1;
                            end else begin
                                state <= fpga_reg_pkg::DATA;
                            end
                        end
                    end
                end

                fpga_reg_pkg::REQ: begin
                    if (bus.ack) begin
                        req_q <= 1'b0;
                        state <= fpga_reg_pkg::WAIT_ACK;
                    end
                end

                fpga_reg_pkg::WAIT_ACK: begin
                    if (!bus.ack) begin
                        if (frame_op == fpga_reg_pkg::REG_OP_RD && cs_active_i)
                            state <= fpga_reg_pkg::DATA;
                        else
                            state <= fpga_reg_pkg::DONE;
                    end
                end

                fpga_reg_pkg::DATA: begin
                    if (!cs_active_i) begin
                        state      <= fpga_reg_pkg::IDLE;   // no request for a cut write
                        spi_miso_o <= 1'b0;
                    end else begin
                        if (sclk_fall_i && frame_op == fpga_reg_pkg::REG_OP_RD)
                            spi_miso_o <= rd_shift[fpga_reg_pkg::REG_DWIDTH-1];
                        if (sclk_rise_i) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == FRAME_LAST) begin
                                spi_miso_o <= 1'b0;
                                if (frame_op == fpga_reg_pkg::REG_OP_WR) begin
                                    state <= fpga_reg_pkg::REQ;
                                    req_q <= 1'b1;
                                end else begin
                                    state <= fpga_reg_pkg::DONE;
                                end
                            end
                        end
                    end
                end

                fpga_reg_pkg::DONE: begin
                    spi_miso_o <= 1'b0;
                    if (!cs_active_i) state <= fpga_reg_pkg::IDLE;
                end

                default: state <= fpga_reg_pkg::IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // shift registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (state == fpga_reg_pkg::ADDR && sclk_rise_i) addr_byte <= addr_next;
        if (state == fpga_reg_pkg::DATA && sclk_rise_i)
            wr_data <= {wr_data[fpga_reg_pkg::REG_DWIDTH-2:0], mosi_i};   // msb first

        if (state == fpga_reg_pkg::REQ && bus.ack)
            rd_shift <= bus.rdata;   // captured with ack
        else if (state == fpga_reg_pkg::DATA && sclk_fall_i)
            rd_shift <= {rd_shift[fpga_reg_pkg::REG_DWIDTH-2:0], 1'b0};
    end

    // host side of the handshake only drops req once ack was seen
    a_req_fall_after_ack : assert property (
        @(posedge clk125M) disable iff (rst_i)
        $fell(bus.req) |-> bus.ack
    ) else $error("req dropped while ack low");

endmodule

//--- verilog/reg_bank.sv
//--------------------------------------------------------------------------
// host register bank with write decode, read mux, phy reset and mdio bit-bang
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module reg_bank #(
    parameter int PHY_COUNT        = 4,   // 1..4
    parameter int TEST_ARRAY_COUNT = 8    // 1..16
) (
    input  logic                 clk125M,
    input  logic                 rst_i,
    reg_bus_if.bank              bus,
    input  logic [31:0]          fw_date_i,
    input  logic [31:0]          fw_time_i,
    input  logic [PHY_COUNT-1:0] mac_link_i,
    input  logic                 mdio_i,
    output logic [PHY_COUNT-1:0] phy_rst_o,
    output logic                 mdc_o,
    output logic                 mdio_data_o,
    output logic                 mdio_dir_o
);

    localparam int DW = fpga_reg_pkg::REG_DWIDTH;

    fpga_reg_pkg::reg_data_t test_array [TEST_ARRAY_COUNT];
    fpga_reg_pkg::reg_data_t rd_mux;
    fpga_reg_pkg::reg_data_t rdata_q;
    logic [1:0]              mdio_sync;   // mdio pin into clk125M
    logic                    ack_q;
    logic                    req_new;     // first cycle of a request
    logic                    wr_en;

    assign req_new   = bus.req & ~ack_q;
    assign wr_en     = req_new & (bus.op == fpga_reg_pkg::REG_OP_WR);
    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    //----------------------------------------------------------------------
    // handshake with ack following req one cycle late
    //----------------------------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i)
            ack_q <= 1'b0;
        else
            ack_q <= bus.req;
    end

    always_ff @(posedge clk125M) begin
        mdio_sync <= {mdio_sync[0], mdio_i};
        if (req_new) rdata_q <= rd_mux;   // valid with ack
    end

    //----------------------------------------------------------------------
    // write registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk125M) begin
        if (rst_i) begin
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) test_array[i] <= '0;
            phy_rst_o   <= '0;
            mdc_o       <= 1'b0;
            mdio_data_o <= 1'b0;
            mdio_dir_o  <= 1'b0;   // mdio released
        end else if (wr_en) begin
            for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                if (bus.addr == fpga_reg_pkg::reg_addr_t'(fpga_reg_pkg::ADDR_TEST_ARRAY + i))
                    test_array[i] <= bus.wdata;
            end
            case (bus.addr)
                fpga_reg_pkg::ADDR_PHY_RST:     phy_rst_o   <= bus.wdata[PHY_COUNT-1:0];
                fpga_reg_pkg::ADDR_MDIO_CLK:    mdc_o       <= bus.wdata[0];
                fpga_reg_pkg::ADDR_MDIO_DATA_O: mdio_data_o <= bus.wdata[0];
                fpga_reg_pkg::ADDR_MDIO_DIR:    mdio_dir_o  <= bus.wdata[0];
                default: ;   // writes to status and unmapped addresses ignored
            endcase
        end
    end

    //----------------------------------------------------------------------
    // read mux
    //----------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;   // unused upper bits stay 0
        case (bus.addr)
            fpga_reg_pkg::ADDR_FW_DATE_LO:  rd_mux = fw_date_i[DW-1:0];
            fpga_reg_pkg::ADDR_FW_DATE_HI:  rd_mux = fw_date_i[2*DW-1:DW];
            fpga_reg_pkg::ADDR_FW_TIME_LO:  rd_mux = fw_time_i[DW-1:0];
            fpga_reg_pkg::ADDR_FW_TIME_HI:  rd_mux = fw_time_i[2*DW-1:DW];
            fpga_reg_pkg::ADDR_MAC_LINK:    rd_mux[PHY_COUNT-1:0] = mac_link_i;
            fpga_reg_pkg::ADDR_PHY_RST:     rd_mux[PHY_COUNT-1:0] = phy_rst_o;
            fpga_reg_pkg::ADDR_MDIO_CLK:    rd_mux[0] = mdc_o;
            fpga_reg_pkg::ADDR_MDIO_DATA_O: rd_mux[0] = mdio_data_o;
            fpga_reg_pkg::ADDR_MDIO_DIR:    rd_mux[0] = mdio_dir_o;
            fpga_reg_pkg::ADDR_MDIO_DATA_I: rd_mux[0] = mdio_sync[1];
            default: begin
                // scratch registers or 0 for anything else
                for (int i = 0; i < TEST_ARRAY_COUNT; i++) begin
                    if (bus.addr ==
                        fpga_reg_pkg::reg_addr_t'(fpga_reg_pkg::ADDR_TEST_ARRAY + i))
                        rd_mux = test_array[i];
                end
            end
        endcase
    end

    // bank side of the handshake answers only a pending request
    a_ack_needs_req : assert property (
        @(posedge clk125M) disable iff (rst_i)
        $rose(bus.ack) |-> bus.req
    ) else $error("ack raised without req");

endmodule

//--- verilog/spi_reg_top.sv
//--------------------------------------------------------------------------
// spi host register path with pin sync, frame engine, register bank and mdio pin
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_reg_top #(
    parameter int PHY_COUNT        = 4,
    parameter int TEST_ARRAY_COUNT = 8
) (
    input  logic                 clk125M,
    input  logic                 rst_i,
    input  logic                 spi_clk_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    output logic                 spi_miso_o,
    input  logic [31:0]          fw_date_i,
    input  logic [31:0]          fw_time_i,
    input  logic [PHY_COUNT-1:0] mac_link_i,
    output logic [PHY_COUNT-1:0] phy_rst_o,
    output logic                 mdc_o,
    inout  wire                  mdio_io
);

    logic sclk_rise;
    logic sclk_fall;
    logic cs_active;
    logic mosi_bit;
    logic mdio_data;
    logic mdio_dir;

    reg_bus_if reg_bus ();

    spi_pin_sync m_pin_sync (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .spi_clk_i   (spi_clk_i),
        .spi_cs_n_i  (spi_cs_n_i),
        .spi_mosi_i  (spi_mosi_i),
        .sclk_rise_o (sclk_rise),
        .sclk_fall_o (sclk_fall),
        .cs_active_o (cs_active),
        .mosi_o      (mosi_bit)
    );

    spi_frame m_frame (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .sclk_rise_i (sclk_rise),
        .sclk_fall_i (sclk_fall),
        .cs_active_i (cs_active),
        .mosi_i      (mosi_bit),
        .spi_miso_o  (spi_miso_o),
        .bus         (reg_bus.host)
    );

    reg_bank #(
        .PHY_COUNT        (PHY_COUNT),
        .TEST_ARRAY_COUNT (TEST_ARRAY_COUNT)
    ) m_bank (
        .clk125M     (clk125M),
        .rst_i       (rst_i),
        .bus         (reg_bus.bank),
        .fw_date_i   (fw_date_i),
        .fw_time_i   (fw_time_i),
        .mac_link_i  (mac_link_i),
        .mdio_i      (mdio_io),     // pin read back and synchronized in the bank
        .phy_rst_o   (phy_rst_o),
        .mdc_o       (mdc_o),
        .mdio_data_o (mdio_data),
        .mdio_dir_o  (mdio_dir)
    );

    // mdio tristate released unless dir is set
    assign mdio_io = mdio_dir ? mdio_data : 1'bz;

endmodule

//--- tests/spi_reg_tb.sv
//--------------------------------------------------------------------------
// testbench for the spi host register path with spi host model, data file
// driven checker, watchdog and result report
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module spi_reg_tb;

    localparam int          HALF     = 10;   // spi half period in clk125M cycles
    localparam int          MAX_OPS  = 64;
    localparam logic [31:0] FW_DATE  = 32'h1a2b3c4d;
    localparam logic [31:0] FW_TIME  = 32'h5e6f7081;
    localparam logic [3:0]  MAC_LINK = 4'b1010;

    logic        clk125M;
    logic        rst_i;
    logic        spi_clk;
    logic        spi_cs_n;
    logic        spi_mosi;
    logic        spi_miso;
    logic [31:0] fw_date;
    logic [31:0] fw_time;
    logic [3:0]  mac_link;
    logic [3:0]  phy_rst;
    logic        mdc;
    wire         mdio_io;
    logic        mdio_drive_en;
    logic        mdio_drive_val;

    // pins sampled 8 cycles after the last rising spi edge of a frame
    logic [3:0]  phy_rst_snap;
    logic        mdc_snap;
    logic        mdio_snap;

    // operations from the data file
    int          num_ops;
    int          op_test [MAX_OPS];
    logic [7:0]  op_code [MAX_OPS];
    logic [6:0]  op_addr [MAX_OPS];
    logic [15:0] op_val  [MAX_OPS];

    logic [15:0] rand_exp [128];   // last random word written per address
    int          seed = 25456;
    int          cur_test;
    int          test_checks;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          total_errors;

    pullup (mdio_io);
    assign mdio_io = mdio_drive_en ? mdio_drive_val : 1'bz;   // phy side driver

    spi_reg_top UUT (
        .clk125M    (clk125M),
        .rst_i      (rst_i),
        .spi_clk_i  (spi_clk),
        .spi_cs_n_i (spi_cs_n),
        .spi_mosi_i (spi_mosi),
        .spi_miso_o (spi_miso),
        .fw_date_i  (fw_date),
        .fw_time_i  (fw_time),
        .mac_link_i (mac_link),
        .phy_rst_o  (phy_rst),
        .mdc_o      (mdc),
        .mdio_io    (mdio_io)
    );

    initial begin
        clk125M = 1'b0;
        forever #4 clk125M = ~clk125M;
    end

    // inputs change 1 ns after the rising clock edge
    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk125M);
        #1;
    endtask

    //----------------------------------------------------------------------
    // spi host in mode 0 with msb first
    //----------------------------------------------------------------------
    task automatic spi_transfer(input logic [7:0] addr_byte, input logic [15:0] wdata,
                                output logic [15:0] rdata);
        logic [23:0] frame;
        frame    = {addr_byte, wdata};
        rdata    = '0;
        spi_cs_n = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            spi_mosi = frame[i];
            next_cycles(HALF);
            if (i < 16) rdata = {rdata[14:0], spi_miso};   // sampled at the rising edge
            spi_clk = 1'b1;
            if (i == 0) begin
                next_cycles(8);
                phy_rst_snap = phy_rst;
                mdc_snap     = mdc;
                mdio_snap    = mdio_io;
                next_cycles(HALF - 8);
            end else begin
                next_cycles(HALF);
            end
            spi_clk = 1'b0;
        end
        next_cycles(HALF);
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        next_cycles(2 * HALF);   // gap between frames
    endtask

    task automatic load_ops();
        int          fd;
        int          cnt;
        int          tnum;
        logic [7:0]  code;
        logic [15:0] addr;
        logic [15:0] val;
        logic [8*96-1:0] line;
        num_ops = 0;
        fd = $fopen("tests/spi_reg_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_ops < MAX_OPS) begin
                line = '0;
                cnt  = $fgets(line, fd);
                cnt  = $sscanf(line, "%d %s %h %h", tnum, code, addr, val);
                if (cnt == 4) begin   // comment and blank lines do not parse
                    op_test[num_ops] = tnum;
                    op_code[num_ops] = code;
                    op_addr[num_ops] = addr[6:0];
                    op_val[num_ops]  = val;
                    num_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_mismatch(input string sig_name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("** Error at %0t ns: %s = 0x%04h, expected 0x%04h", $time, sig_name,
                 got, exp);
        test_errors++;
    endtask

    task automatic finish_test();
        if (cur_test != 0) begin
            tests_run++;
            if (test_errors != 0) tests_failed++;
            total_errors += test_errors;
            $display("test %0d %s: %0d checks, %0d errors", cur_test,
                     (test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin : main
        logic [15:0] rd;
        logic [15:0] expected;
        logic [15:0] got;
        string       pin_name;
        rst_i = 1'b1;
        spi_clk = 1'b0;
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        fw_date = FW_DATE;
        fw_time = FW_TIME;
        mac_link = MAC_LINK;
        mdio_drive_en = 1'b0;
        mdio_drive_val = 1'b0;
        cur_test = 0;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
        load_ops();
        if (num_ops == 0) begin
            $display("no operations could be read from tests/spi_reg_testdata.txt");
            $display("Test failed");
            $finish;
        end else begin
            next_cycles(16);
            rst_i = 1'b0;
            next_cycles(4);
            for (int k = 0; k < num_ops; k++) begin
                if (op_test[k] != cur_test) begin
                    finish_test();
                    cur_test = op_test[k];
                end
                case (op_code[k])
                    "W": spi_transfer({1'b0, op_addr[k]}, op_val[k], rd);
                    "S": begin
                        expected = 16'($random(seed));
                        rand_exp[op_addr[k]] = expected;
                        spi_transfer({1'b0, op_addr[k]}, expected, rd);
                    end
                    "R", "C": begin
                        spi_transfer({1'b1, op_addr[k]}, 16'h0000, rd);
                        expected = (op_code[k] == "C") ? rand_exp[op_addr[k]] : op_val[k];
                        pin_name = $sformatf("spi_miso_o read of 0x%02h", op_addr[k]);
                        test_checks++;
                        if (rd !== expected) begin
                            report_mismatch(pin_name, rd, expected);
                        end
                    end
                    "P": begin
                        case (op_addr[k])
                            7'd0: begin
                                got      = {12'h000, phy_rst_snap};
                                pin_name = "phy_rst_o";
                            end
                            7'd1: begin
                                got      = {15'h0000, mdc_snap};
                                pin_name = "mdc_o";
                            end
                            default: begin
                                got      = {15'h0000, mdio_snap};
                                pin_name = "mdio_io";
                            end
                        endcase
                        test_checks++;
                        if (got !== op_val[k]) begin
                            report_mismatch(pin_name, got, op_val[k]);
                        end
                    end
                    "D": begin
                        mdio_drive_en  = (op_val[k] != 16'h0002);   // 2 releases the pin
                        mdio_drive_val = op_val[k][0];
                        next_cycles(4);
                    end
                    default: begin
                        $display("unknown operation in data file entry %0d", k);
                        test_errors++;
                    end
                endcase
            end
            finish_test();
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                     total_errors);
            if (total_errors == 0 && tests_failed == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // run limit from the number of operations at one frame each
    initial begin : watchdog
        wait (num_ops != 0);
        #(num_ops * 24 * 20 * 8 * 2);
        $display("timeout, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

//--- tests/spi_reg_testdata.txt
# columns: test op addr(hex) value(hex); W write, R read and expect value, S write random,
# C read and expect last random, P pin check (addr 0 phy_rst_o, 1 mdc_o, 2 mdio_io), D drive mdio (2 = off)
1 S 10 0000
1 S 11 0000
1 S 12 0000
1 S 17 0000
1 S 12 0000
1 C 10 0000
1 C 11 0000
1 C 12 0000
1 C 17 0000
2 R 00 3c4d
2 R 01 1a2b
2 R 02 7081
2 R 03 5e6f
2 R 04 000a
3 W 05 fff6
3 P 00 0006
3 R 05 0006
4 W 08 0001
4 W 07 0000
4 P 02 0000
4 W 07 0001
4 P 02 0001
4 W 06 0001
4 P 01 0001
4 R 06 0001
5 W 08 0000
5 D 00 0000
5 R 09 0000
5 D 00 0001
5 R 09 0001
5 D 00 0002
6 R 0a 0000
6 R 18 0000
6 R 7f 0000
6 W 04 ffff
6 R 04 000a

//--- filelist.f
verilog/fpga_reg_pkg.sv
verilog/reg_bus_if.sv
verilog/spi_pin_sync.sv
verilog/spi_frame.sv
verilog/reg_bank.sv
verilog/spi_reg_top.sv
tests/spi_reg_tb.sv
